/* verification/aging_cases.txt */
# late_cycles expected_count expected_level saturated
# one window per line, decimal, window of 32 capture cycles
0 0 0 0
1 1 1 0
2 2 2 0
3 3 2 0
5 5 3 0
7 7 3 0
8 8 4 0
12 12 4 0
15 15 4 0
16 15 4 1
25 15 4 1
32 15 4 1

/* compile.f */
hw/aging_pkg.sv
hw/report_if.sv
hw/path_monitor.sv
hw/window_accumulator.sv
hw/report_fifo.sv
hw/uart_reporter.sv
hw/aging_sensor_top.sv
verification/tb_aging_sensor.sv

/* Makefile */
TOP = tb_aging_sensor

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir

/* verification/tb_aging_sensor.sv */
`timescale 1ns/1ps

module tb_aging_sensor;
   import aging_pkg::*;

   // dut sizes
   // window shorter than a frame so the fifo overflows within the run
   localparam int count_width    = default_count_width;
   localparam int window_cycles  = 32;
   localparam int fifo_depth     = default_fifo_depth;
   localparam int cycles_per_bit = default_cycles_per_bit;

   logic                   clk;
   logic                   reset_Q1;
   logic                   enable;
   logic                   probe_return;
   logic                   probe_launch;
   logic [level_width-1:0] aging_level;
   logic                   level_valid;
   logic                   report_lost;
   logic                   txd;

   int           value_errors;
   int           other_errors;
   int           seed;
   int           num_cases;
   // one entry per window from the case file
   int           case_late[$];
   int           case_count[$];
   int           case_level[$];
   int           case_sat[$];
   // reports still owed on the serial line, oldest first
   report_byte_t exp_q[$];
   int           windows_done;
   int           lost_count;
   int           frames_rx;
   // consecutive cycles with the serial line idle
   int           quiet_cycles;
   uart_state_t  rx_state;
   logic         late_map [window_cycles];
   int           fd;
   int           rc;
   int           n_late;
   int           n_cnt;
   int           n_lvl;
   int           n_sat;
   string        line;

   aging_sensor_top #(
      .count_width    (count_width),
      .window_cycles  (window_cycles),
      .fifo_depth     (fifo_depth),
      .cycles_per_bit (cycles_per_bit)
   ) UUT (
      .clk          (clk),
      .reset_Q1     (reset_Q1),
      .enable       (enable),
      .probe_return (probe_return),
      .probe_launch (probe_launch),
      .aging_level  (aging_level),
      .level_valid  (level_valid),
      .report_lost  (report_lost),
      .txd          (txd)
   );

   // one level per bit up to the top set bit
   function automatic logic [level_width-1:0] level_from_count(input int count);
      int                     remaining;
      logic [level_width-1:0] lvl;
      remaining = count;
      lvl = '0;
      while (remaining != 0) begin
         lvl = lvl + 1'b1;
         remaining = remaining >> 1;
      end
      return lvl;
   endfunction

   // report byte as the case file describes it
   function automatic report_byte_t expected_byte(input int idx);
      report_byte_t b;
      b.saturated = (case_sat[idx] != 0);
      b.level     = level_width'(case_level[idx]);
      b.count     = 4'(case_count[idx]);
      return b;
   endfunction

   task automatic report_problem(input string what);
      other_errors++;
      $display("[ERROR] %0t %s", $time, what);
   endtask

   task automatic check_level(input string name, input logic [level_width-1:0] actual,
                              input logic [level_width-1:0] expected);
      if (actual !== expected) begin
         value_errors++;
         $display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
      end
   endtask

   task automatic check_byte(input string name, input report_byte_t actual,
                             input report_byte_t expected);
      if (actual !== expected) begin
         value_errors++;
         $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         value_errors++;
         $display("[FAIL] %0t %s expected %b got %b", $time, name, expected, actual);
      end
   endtask

   task automatic check_reset_state();
      check_bit("txd", txd, 1'b1);
      check_bit("level_valid", level_valid, 1'b0);
      check_bit("report_lost", report_lost, 1'b0);
      check_bit("probe_launch", probe_launch, 1'b0);
      check_level("aging_level", aging_level, '0);
   endtask

   // scatter the late cycles over the window slots
   task automatic pick_late_cycles(input int count);
      int placed;
      int slot;
      foreach (late_map[i])
         late_map[i] = 1'b0;
      placed = 0;
      while (placed < count && placed < window_cycles) begin
         slot = $unsigned($random(seed)) % window_cycles;
         if (!late_map[slot]) begin
            late_map[slot] = 1'b1;
            placed++;
         end
      end
   endtask

   initial begin : clock_gen
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin : watchdog
      int limit;
      @(posedge clk);
      // case count known by the first edge
      limit = (num_cases + fifo_depth + 2) * (window_cycles + 10 * cycles_per_bit);
      repeat (limit) @(posedge clk);
      $display("timeout after %0d cycles without the run finishing", limit);
      $display("=== FAIL ===");
      $finish;
   end

   // window results and dropped reports
   always @(posedge clk) begin
      if (level_valid) begin
         if (windows_done >= num_cases) begin
            report_problem("level_valid pulsed after the last window");
         end else begin
            check_level("aging_level", aging_level,
                        level_from_count(case_count[windows_done]));
            exp_q.push_back(expected_byte(windows_done));
            windows_done++;
         end
      end
      // a drop always hits the report of the window just finished
      if (report_lost) begin
         lost_count++;
         if (exp_q.size() == 0)
            report_problem("report_lost pulsed with no report outstanding");
         else
            void'(exp_q.pop_back());
      end
   end

   // 8N1 receiver, samples mid bit
   initial begin : uart_decoder
      report_byte_t rx_byte;
      rx_state = idle;
      forever begin
         @(posedge clk);
         if (!reset_Q1 && txd === 1'b0) begin
            rx_state = start;
            repeat (cycles_per_bit / 2 - 1) @(posedge clk);
            check_bit("txd start bit", txd, 1'b0);
            rx_state = data;
            // lsb first
            for (int i = 0; i < 8; i++) begin
               repeat (cycles_per_bit) @(posedge clk);
               rx_byte[i] = txd;
            end
            rx_state = stop;
            repeat (cycles_per_bit) @(posedge clk);
            check_bit("txd stop bit", txd, 1'b1);
            frames_rx++;
            if (exp_q.size() == 0)
               report_problem("uart frame arrived with no report pending");
            else
               check_byte("uart report byte", rx_byte, exp_q.pop_front());
            rx_state = idle;
         end
      end
   end

   initial begin : stimulus
      reset_Q1     = 1'b1;
      enable       = 1'b0;
      probe_return = 1'b0;
      value_errors = 0;
      other_errors = 0;
      windows_done = 0;
      lost_count   = 0;
      frames_rx    = 0;
      quiet_cycles = 0;
      seed         = 98;
      num_cases    = 0;
      fd = $fopen("verification/aging_cases.txt", "r");
      if (fd == 0) begin
         report_problem("cannot open verification/aging_cases.txt");
      end else begin
         while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            // header lines start with a hash
            if (rc > 0 && line.getc(0) != "#") begin
               if ($sscanf(line, "%d %d %d %d", n_late, n_cnt, n_lvl, n_sat) == 4) begin
                  case_late.push_back(n_late);
                  case_count.push_back(n_cnt);
                  case_level.push_back(n_lvl);
                  case_sat.push_back(n_sat);
               end
            end
         end
         $fclose(fd);
         num_cases = case_late.size();
         if (num_cases == 0)
            report_problem("case file holds no windows");
      end
      // reset held for 10 cycles, checked in the middle and after release
      repeat (5) @(posedge clk);
      check_reset_state();
      repeat (5) @(posedge clk);
      reset_Q1 <= 1'b0;
      @(posedge clk);
      check_reset_state();
      for (int w = 0; w < num_cases; w++) begin
         if (case_late[w] > window_cycles)
            report_problem($sformatf("window %0d asks for too many late cycles", w));
         pick_late_cycles(case_late[w]);
         for (int s = 0; s < window_cycles; s++) begin
            @(posedge clk);
            enable <= 1'b1;
            // on time is the value launched at this edge, late keeps the old one
            probe_return <= (enable ? ~probe_launch : probe_launch) ^ late_map[s];
         end
      end
      @(posedge clk);
      enable <= 1'b0;
      // drain the fifo through the uart
      // done once the line has idled for two bit periods
      quiet_cycles = 0;
      while (quiet_cycles < 2 * cycles_per_bit) begin
         @(posedge clk);
         if (windows_done == num_cases && rx_state == idle && txd === 1'b1)
            quiet_cycles++;
         else
            quiet_cycles = 0;
      end
      if (frames_rx + lost_count != windows_done)
         report_problem($sformatf("%0d frames and %0d drops do not add up to %0d windows",
                                  frames_rx, lost_count, windows_done));
      $display("windows %0d frames %0d lost %0d value errors %0d other errors %0d",
               windows_done, frames_rx, lost_count, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

/* hw/aging_sensor_top.sv */
`timescale 1ns/1ps

module aging_sensor_top #(
   parameter int count_width    = aging_pkg::default_count_width,
   parameter int window_cycles  = aging_pkg::default_window_cycles,
   parameter int fifo_depth     = aging_pkg::default_fifo_depth,
   parameter int cycles_per_bit = aging_pkg::default_cycles_per_bit
) (
   input  logic                              clk,
   input  logic                              reset_Q1,
   input  logic                              enable,
   input  logic                              probe_return,
   output logic                              probe_launch,
   output logic [aging_pkg::level_width-1:0] aging_level,
   output logic                              level_valid,
   output logic                              report_lost,
   output logic                              txd
);
   import aging_pkg::*;

   logic         late_strobe;
   report_byte_t head;
   logic         not_empty;
   logic         pop;

   // window report bus
   report_if #(.count_width(count_width)) rpt_bus ();

   // launch and capture probe
   path_monitor u_path_monitor (
      .clk          (clk),
      .reset_Q1     (reset_Q1),
      .enable       (enable),
      .probe_return (probe_return),
      .probe_launch (probe_launch),
      .late_strobe  (late_strobe)
   );

   // counts late events per window and grades them
   window_accumulator #(
      .count_width   (count_width),
      .window_cycles (window_cycles)
   ) u_window_accumulator (
      .clk         (clk),
      .reset_Q1    (reset_Q1),
      .enable      (enable),
      .late_strobe (late_strobe),
      .rpt         (rpt_bus.producer),
      .aging_level (aging_level),
      .level_valid (level_valid)
   );

   // absorbs reports while the uart is busy
   report_fifo #(
      .fifo_depth (fifo_depth)
   ) u_report_fifo (
      .clk         (clk),
      .reset_Q1    (reset_Q1),
      .rpt         (rpt_bus.buffer),
      .pop         (pop),
      .head        (head),
      .not_empty   (not_empty),
      .report_lost (report_lost)
   );

   // serial report output
   uart_reporter #(
      .cycles_per_bit (cycles_per_bit)
   ) u_uart_reporter (
      .clk       (clk),
      .reset_Q1  (reset_Q1),
      .head      (head),
      .not_empty (not_empty),
      .pop       (pop),
      .txd       (txd)
   );

endmodule

/* hw/uart_reporter.sv */
`timescale 1ns/1ps

module uart_reporter #(
   parameter int cycles_per_bit = aging_pkg::default_cycles_per_bit
) (
   input  logic                    clk,
   input  logic                    reset_Q1,
   input  aging_pkg::report_byte_t head,
   input  logic                    not_empty,
   output logic                    pop,
   output logic                    txd
);
   import aging_pkg::*;

   localparam int cnt_width = (cycles_per_bit > 1) ? $clog2(cycles_per_bit) : 1;

   uart_state_t          state_q;
   logic [cnt_width-1:0] bit_cnt_q;
   logic [2:0]           bit_idx_q;
   logic [7:0]           shift_q;
   logic                 txd_q;
   logic                 bit_end;

   // last clock of the current bit period
   assign bit_end = (bit_cnt_q == cnt_width'(cycles_per_bit - 1));

   // take a byte only between frames
   assign pop = (state_q == idle) & not_empty;

   always_ff @(posedge clk or posedge reset_Q1) begin
      if (reset_Q1) begin
         state_q   <= idle;
         bit_cnt_q <= '0;
         bit_idx_q <= '0;
         txd_q     <= 1'b1;
      end else begin
         case (state_q)
            idle: begin
               bit_cnt_q <= '0;
               if (pop) begin
                  // start bit goes out next cycle
                  state_q <= start;
                  txd_q   <= 1'b0;
               end
            end
            start: begin
               if (bit_end) begin
                  bit_cnt_q <= '0;
                  bit_idx_q <= '0;
                  // lsb first
                  txd_q     <= shift_q[0];
                  state_q   <= data;
               end else begin
                  bit_cnt_q <= bit_cnt_q + 1'b1;
               end
            end
            data: begin
               if (bit_end) begin
                  bit_cnt_q <= '0;
                  if (bit_idx_q == 3'd7) begin
                     txd_q   <= 1'b1;
                     state_q <= stop;
                  end else begin
                     // shift_q moves down on this same edge
                     txd_q     <= shift_q[1];
                     bit_idx_q <= bit_idx_q + 1'b1;
                  end
               end else begin
                  bit_cnt_q <= bit_cnt_q + 1'b1;
               end
            end
            stop: begin
               if (bit_end) begin
                  bit_cnt_q <= '0;
                  state_q   <= idle;
               end else begin
                  bit_cnt_q <= bit_cnt_q + 1'b1;
               end
            end
            default: state_q <= idle;
         endcase
      end
   end

   // frame payload
   always_ff @(posedge clk) begin
      if (pop)
         shift_q <= head;
      else if (bit_end && state_q == data)
         shift_q <= {1'b0, shift_q[7:1]};
   end

   assign txd = txd_q;

endmodule

/* hw/report_fifo.sv */
`timescale 1ns/1ps

module report_fifo #(
   parameter int fifo_depth = aging_pkg::default_fifo_depth
) (
   input  logic                   clk,
   input  logic                   reset_Q1,
   report_if.buffer               rpt,
   input  logic                   pop,
   output aging_pkg::report_byte_t head,
   output logic                   not_empty,
   output logic                   report_lost
);
   import aging_pkg::*;

   localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int occ_width = $clog2(fifo_depth + 1);

   report_byte_t           mem [fifo_depth];
   logic [ptr_width-1:0]   wr_ptr_q;
   logic [ptr_width-1:0]   rd_ptr_q;
   logic [occ_width-1:0]   occ_q;
   logic                   full;
   logic                   do_push;
   logic                   do_pop;
   logic                   lost_q;
   logic [7:0]             count_ext;
   report_byte_t           in_byte;

   // wrap at depth, depth need not be a power of two
   function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] p);
      if (p == ptr_width'(fifo_depth - 1))
         return '0;
      return p + 1'b1;
   endfunction

   // pack the report, only the low nibble of the count fits
   always_comb begin
      count_ext         = 8'(rpt.count);
      in_byte.saturated = rpt.saturated;
      in_byte.level     = rpt.level;
      in_byte.count     = count_ext[3:0];
   end

   assign full    = (occ_q == occ_width'(fifo_depth));
   assign do_pop  = pop & (occ_q != '0);
   // a pop in the same cycle frees a slot
   assign do_push = rpt.valid & (~full | do_pop);

   always_ff @(posedge clk or posedge reset_Q1) begin
      if (reset_Q1) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         occ_q    <= '0;
         lost_q   <= 1'b0;
      end else begin
         if (do_push)
            wr_ptr_q <= next_ptr(wr_ptr_q);
         if (do_pop)
            rd_ptr_q <= next_ptr(rd_ptr_q);
         case ({do_push, do_pop})
            2'b10:   occ_q <= occ_q + 1'b1;
            2'b01:   occ_q <= occ_q - 1'b1;
            default: occ_q <= occ_q;
         endcase
         // report arrived but had nowhere to go
         lost_q <= rpt.valid & ~do_push;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr_q] <= in_byte;
   end

   // fall-through head
   assign head        = mem[rd_ptr_q];
   assign not_empty   = (occ_q != '0);
   assign report_lost = lost_q;

endmodule

/* hw/window_accumulator.sv */
`timescale 1ns/1ps

module window_accumulator #(
   parameter int count_width   = aging_pkg::default_count_width,
   parameter int window_cycles = aging_pkg::default_window_cycles
) (
   input  logic                               clk,
   input  logic                               reset_Q1,
   input  logic                               enable,
   input  logic                               late_strobe,
   report_if.producer                         rpt,
   output logic [aging_pkg::level_width-1:0]  aging_level,
   output logic                               level_valid
);
   import aging_pkg::*;

   localparam int timer_width = (window_cycles > 1) ? $clog2(window_cycles) : 1;
   localparam logic [count_width-1:0] count_max = '1;

   logic [timer_width-1:0] timer_q;
   // last capture of the window happened on the previous edge
   logic                   closing_q;
   logic [count_width-1:0] count_q;
   logic                   overflow_q;
   logic [count_width-1:0] final_count;
   logic                   final_overflow;
   logic                   level_valid_q;
   logic [level_width-1:0] level_q;
   logic [count_width-1:0] rpt_count_q;
   logic                   rpt_sat_q;

   // highest set bit plus one, zero count gives level 0
   function automatic logic [level_width-1:0] grade(input logic [count_width-1:0] c);
      logic [level_width-1:0] lvl;
      lvl = '0;
      for (int i = 0; i < count_width; i++) begin
         if (c[i])
            lvl = level_width'(i + 1);
      end
      return lvl;
   endfunction

   // count including the strobe present this cycle, saturating
   always_comb begin
      final_count    = count_q;
      final_overflow = overflow_q;
      if (late_strobe) begin
         if (count_q == count_max)
            final_overflow = 1'b1;
         else
            final_count = count_q + 1'b1;
      end
   end

   // window timer, advances on enabled cycles only
   always_ff @(posedge clk or posedge reset_Q1) begin
      if (reset_Q1) begin
         timer_q   <= '0;
         closing_q <= 1'b0;
      end else begin
         closing_q <= 1'b0;
         if (enable) begin
            if (timer_q == timer_width'(window_cycles - 1)) begin
               timer_q   <= '0;
               closing_q <= 1'b1;
            end else begin
               timer_q <= timer_q + 1'b1;
            end
         end
      end
   end

   // late-event counter
   // the strobe seen while closing belongs to the old window
   always_ff @(posedge clk or posedge reset_Q1) begin
      if (reset_Q1) begin
         count_q    <= '0;
         overflow_q <= 1'b0;
      end else if (closing_q) begin
         count_q    <= '0;
         overflow_q <= 1'b0;
      end else begin
         count_q    <= final_count;
         overflow_q <= final_overflow;
      end
   end

   // level held until the next window ends
   always_ff @(posedge clk or posedge reset_Q1) begin
      if (reset_Q1) begin
         level_valid_q <= 1'b0;
         level_q       <= '0;
      end else begin
         level_valid_q <= closing_q;
         if (closing_q)
            level_q <= grade(final_count);
      end
   end

   always_ff @(posedge clk) begin
      if (closing_q) begin
         rpt_count_q <= final_count;
         rpt_sat_q   <= final_overflow;
      end
   end

   assign rpt.valid     = level_valid_q;
   assign rpt.count     = rpt_count_q;
   assign rpt.level     = level_q;
   assign rpt.saturated = rpt_sat_q;
   assign aging_level   = level_q;
   assign level_valid   = level_valid_q;

endmodule

/* hw/path_monitor.sv */
`timescale 1ns/1ps

module path_monitor (
   input  logic clk,
   input  logic reset_Q1,
   input  logic enable,
   input  logic probe_return,
   output logic probe_launch,
   output logic late_strobe
);

   // launch flop driving the outgoing probe line
   logic launch_q;
   // local copy of the launched value, sits beside the capture side
   logic launch_copy_q;
   // registered late flag
   logic late_q;

   always_ff @(posedge clk or posedge reset_Q1) begin
      if (reset_Q1) begin
         launch_q      <= 1'b0;
         launch_copy_q <= 1'b0;
         late_q        <= 1'b0;
      end else begin
         // capture edge: returned probe should already match what was sent
         // mismatch means the external path missed the edge
         late_q <= enable & (probe_return != launch_copy_q);
         if (enable) begin
            // new transition every enabled cycle
            launch_q      <= ~launch_q;
            launch_copy_q <= ~launch_q;
         end
      end
   end

   assign probe_launch = launch_q;
   // one cycle after the capture edge
   assign late_strobe  = late_q;

endmodule

/* hw/report_if.sv */
`timescale 1ns/1ps

// one window report, accumulator to fifo
interface report_if #(
   parameter int count_width = aging_pkg::default_count_width
);
   import aging_pkg::*;

   // single-cycle strobe, no back-pressure
   logic                   valid;
   // fields only meaningful while valid is high
   logic [count_width-1:0] count;
   logic [level_width-1:0] level;
   logic                   saturated;

   modport producer (output valid, output count, output level, output saturated);
   modport buffer (input valid, input count, input level, input saturated);

endinterface

/* hw/aging_pkg.sv */
package aging_pkg;

   // default sizes, overridden from the top level
   // late-event count width per window
   localparam int default_count_width = 4;

   // enabled capture cycles per window
   localparam int default_window_cycles = 64;

   // report queue entries
   localparam int default_fifo_depth = 4;

   // clock cycles per uart bit
   localparam int default_cycles_per_bit = 8;

   // aging level 0..7, so count width must stay at 7 or less
   localparam int level_width = 3;

   // one report as it goes out on the serial line
   // msb first: saturation, level, low nibble of count
   typedef struct packed {
      logic                   saturated;
      logic [level_width-1:0] level;
      logic [3:0]             count;
   } report_byte_t;

   // uart transmitter states
   typedef enum logic [1:0] {
      idle  = 2'd0,
      start = 2'd1,
      data  = 2'd2,
      stop  = 2'd3
   } uart_state_t;

endpackage
